// ==== Makefile ====
# Verilator build and run of the decode stage testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run tb_decoder"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_decoder \
		-Mdir obj_dir -f vlog.f
	./obj_dir/Vtb_decoder | tee /dev/stderr | grep -q "TEST PASS"

clean:
	rm -rf obj_dir

// ==== rtl/decode_pkg.sv ====
package decode_pkg;

    typedef enum logic [7:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_LUI,
        ALU_LOAD,
        ALU_STORE,
        ALU_BEQ,
        ALU_BNE,
        ALU_B,
        ALU_BL,
        ALU_CSRRD,
        ALU_CSRWR,
        ALU_RDCNT,
        ALU_INVTLB,
        ALU_SYSCALL,
        ALU_BREAK,
        ALU_ERTN
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_ARITH,
        SEL_LOGIC,
        SEL_SHIFT,
        SEL_MEM,
        SEL_BRANCH,
        SEL_CSR,
        SEL_PRIV
    } alu_sel_e;

    // exception cause codes
    localparam logic [6:0] ECODE_SYS = 7'h0B;
    localparam logic [6:0] ECODE_BRK = 7'h0C;
    localparam logic [6:0] ECODE_INE = 7'h0D;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        pre_taken;
        logic [31:0] pre_addr;
        logic [1:0]  is_exception;               // bit0 pc stage, bit1 inst buffer
        logic [6:0]  pc_exception_cause;
        logic [6:0]  instbuffer_exception_cause;
    } fetch_slot_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        alu_op_e     aluop;
        alu_sel_e    alusel;
        logic [31:0] imm;
        logic        reg1_read_en;
        logic        reg2_read_en;
        logic [4:0]  reg1_read_addr;
        logic [4:0]  reg2_read_addr;
        logic        reg_write_en;
        logic [4:0]  reg_write_addr;
        logic        pre_taken;
        logic [31:0] pre_addr;
        logic        is_privilege;
        logic        csr_read_en;
        logic        csr_write_en;
        logic [13:0] csr_addr;
        logic        is_cnt;
        logic [4:0]  invtlb_op;
        logic [2:0]  is_exception;               // bit2 raised by decoder
        logic [6:0]  pc_exception_cause;
        logic [6:0]  instbuffer_exception_cause;
        logic [6:0]  decoder_exception_cause;
    } decoded_inst_t;

endpackage

// ==== rtl/decode_queue.sv ====
module decode_queue #(
    parameter type payload_t   = logic [31:0],
    parameter int  QUEUE_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush,

    input  logic [1:0] enq_en,
    input  payload_t   enq_data [2],

    input  logic [1:0] deq_ack,
    output logic [1:0] head_valid,
    output payload_t   head_data [2],

    output logic       almost_full
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    payload_t         mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr_p1;
    logic [PTR_W-1:0] lane1_wr_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   free_cnt;
    logic [PTR_W:0]   enq_num;
    logic [PTR_W:0]   deq_num;

    assign enq_num = (PTR_W+1)'(enq_en[0]) + (PTR_W+1)'(enq_en[1]);
    assign deq_num = (PTR_W+1)'(deq_ack[0]) + (PTR_W+1)'(deq_ack[1]);

    assign rd_ptr_p1    = rd_ptr + PTR_W'(1);
    assign lane1_wr_ptr = wr_ptr + PTR_W'(enq_en[0]);   // lane 1 packs behind lane 0

    assign free_cnt    = (PTR_W+1)'(QUEUE_DEPTH) - count;
    assign almost_full = (free_cnt < (PTR_W+1)'(2));

    assign head_valid[0] = (count != '0);
    assign head_valid[1] = (count > (PTR_W+1)'(1));
    assign head_data[0]  = mem[rd_ptr];
    assign head_data[1]  = mem[rd_ptr_p1];

    always_ff @(posedge clk) begin
        if (enq_en[0]) begin
            mem[wr_ptr] <= enq_data[0];
        end
        if (enq_en[1]) begin
            mem[lane1_wr_ptr] <= enq_data[1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + enq_num[PTR_W-1:0];
            rd_ptr <= rd_ptr + deq_num[PTR_W-1:0];
            count  <= count + enq_num - deq_num;   // enq and deq in one cycle
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n || flush)
        enq_num <= free_cnt
    ) else $error("enqueue of %0d entries with %0d free", enq_num, free_cnt);

    a_ack_present: assert property (
        @(posedge clk) disable iff (!rst_n || flush)
        (deq_ack & ~head_valid) == 2'b00
    ) else $error("ack %b of missing entry, valid %b", deq_ack, head_valid);

    a_ack_in_order: assert property (
        @(posedge clk) disable iff (!rst_n || flush)
        deq_ack[1] |-> deq_ack[0]
    ) else $error("second entry acked without the first");

endmodule

// ==== rtl/decoder.sv ====
module decoder
    import decode_pkg::*;
#(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          flush,

    input  logic [1:0]    fetch_valid,
    input  fetch_slot_t   fetch_slot [2],
    output logic          stall,

    output logic [1:0]    out_valid,
    output decoded_inst_t out_inst [2],
    input  logic [1:0]    issue_ack
);

    decoded_inst_t dec [2];
    decoded_inst_t enq_data [2];
    logic [1:0]    enq_en;
    logic          almost_full;
    logic          accept;

    for (genvar i = 0; i < 2; i++) begin : g_dec
        inst_decoder dec_inst (
            .slot (fetch_slot[i]),
            .dec  (dec[i])
        );
    end

    // a lone slot 1 becomes the older entry
    assign enq_data[0] = fetch_valid[0] ? dec[0] : dec[1];
    assign enq_data[1] = dec[1];

    assign accept    = !almost_full && !flush;
    assign enq_en[0] = accept && (|fetch_valid);
    assign enq_en[1] = accept && (&fetch_valid);

    assign stall = almost_full;   // fewer than two free entries

    decode_queue #(
        .payload_t   (decoded_inst_t),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) queue_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .enq_en      (enq_en),
        .enq_data    (enq_data),
        .deq_ack     (issue_ack),
        .head_valid  (out_valid),
        .head_data   (out_inst),
        .almost_full (almost_full)
    );

endmodule

// ==== rtl/inst_decoder.sv ====
module inst_decoder
    import decode_pkg::*;
(
    input  fetch_slot_t   slot,
    output decoded_inst_t dec
);

    localparam logic [16:0] OP17_ADD_W   = 17'h00020;
    localparam logic [16:0] OP17_SUB_W   = 17'h00022;
    localparam logic [16:0] OP17_AND     = 17'h00029;
    localparam logic [16:0] OP17_OR      = 17'h0002A;
    localparam logic [16:0] OP17_XOR     = 17'h0002B;
    localparam logic [16:0] OP17_SLLI_W  = 17'h00081;
    localparam logic [16:0] OP17_BREAK   = 17'h00054;
    localparam logic [16:0] OP17_SYSCALL = 17'h00056;
    localparam logic [16:0] OP17_INVTLB  = 17'h00C93;
    localparam logic [9:0]  OP10_ADDI_W  = 10'h00A;
    localparam logic [9:0]  OP10_LD_W    = 10'h0A2;
    localparam logic [9:0]  OP10_ST_W    = 10'h0A6;
    localparam logic [7:0]  OP8_CSR      = 8'h04;
    localparam logic [6:0]  OP7_LU12I_W  = 7'h0A;
    localparam logic [5:0]  OP6_B        = 6'h14;
    localparam logic [5:0]  OP6_BL       = 6'h15;
    localparam logic [5:0]  OP6_BEQ      = 6'h16;
    localparam logic [5:0]  OP6_BNE      = 6'h17;
    localparam logic [21:0] OP22_RDCNT   = 22'h000018;
    localparam logic [31:0] INST_ERTN    = 32'h0648_3800;

    logic [31:0] inst;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [7:0]  op8;
    logic [6:0]  op7;
    logic [5:0]  op6;
    logic [31:0] imm_si12;
    logic [31:0] imm_ui5;
    logic [31:0] imm_si20;
    logic [31:0] imm_offs16;
    logic [31:0] imm_offs26;
    logic [31:0] imm_code;
    logic        fetch_exc;
    logic        is_3r;
    logic        is_ine;
    logic        is_sys;
    logic        is_brk;

    assign inst = slot.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];
    assign op17 = inst[31:15];
    assign op10 = inst[31:22];
    assign op8  = inst[31:24];
    assign op7  = inst[31:25];
    assign op6  = inst[31:26];

    assign imm_si12   = {{20{inst[21]}}, inst[21:10]};
    assign imm_ui5    = {27'b0, inst[14:10]};
    assign imm_si20   = {inst[24:5], 12'b0};
    assign imm_offs16 = {{14{inst[25]}}, inst[25:10], 2'b00};
    assign imm_offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
    assign imm_code   = {17'b0, inst[14:0]};

    assign fetch_exc = |slot.is_exception;
    assign is_3r = (op17 == OP17_ADD_W) || (op17 == OP17_SUB_W) || (op17 == OP17_AND) ||
                   (op17 == OP17_OR) || (op17 == OP17_XOR);

    always_comb begin
        dec = '0;
        dec.pc        = slot.pc;
        dec.inst      = inst;
        dec.pre_taken = slot.pre_taken;
        dec.pre_addr  = slot.pre_addr;
        is_ine = 1'b0;
        is_sys = 1'b0;
        is_brk = 1'b0;

        if (is_3r) begin
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg2_read_en   = 1'b1;
            dec.reg2_read_addr = rk;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
            dec.alusel = (op17 == OP17_ADD_W || op17 == OP17_SUB_W) ? SEL_ARITH : SEL_LOGIC;
            case (op17)
                OP17_ADD_W: dec.aluop = ALU_ADD;
                OP17_SUB_W: dec.aluop = ALU_SUB;
                OP17_AND:   dec.aluop = ALU_AND;
                OP17_OR:    dec.aluop = ALU_OR;
                default:    dec.aluop = ALU_XOR;
            endcase
        end else if (op17 == OP17_SLLI_W) begin
            dec.aluop          = ALU_SLL;
            dec.alusel         = SEL_SHIFT;
            dec.imm            = imm_ui5;
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
        end else if (op10 == OP10_ADDI_W || op10 == OP10_LD_W) begin
            dec.aluop          = (op10 == OP10_LD_W) ? ALU_LOAD : ALU_ADD;
            dec.alusel         = (op10 == OP10_LD_W) ? SEL_MEM : SEL_ARITH;
            dec.imm            = imm_si12;
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
        end else if (op10 == OP10_ST_W) begin
            dec.aluop          = ALU_STORE;
            dec.alusel         = SEL_MEM;
            dec.imm            = imm_si12;
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg2_read_en   = 1'b1;
            dec.reg2_read_addr = rd;         // store data
        end else if (op7 == OP7_LU12I_W) begin
            dec.aluop          = ALU_LUI;
            dec.alusel         = SEL_ARITH;
            dec.imm            = imm_si20;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
        end else if (op6 == OP6_BEQ || op6 == OP6_BNE) begin
            dec.aluop          = (op6 == OP6_BEQ) ? ALU_BEQ : ALU_BNE;
            dec.alusel         = SEL_BRANCH;
            dec.imm            = imm_offs16;
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg2_read_en   = 1'b1;
            dec.reg2_read_addr = rd;
        end else if (op6 == OP6_B || op6 == OP6_BL) begin
            dec.aluop          = (op6 == OP6_BL) ? ALU_BL : ALU_B;
            dec.alusel         = SEL_BRANCH;
            dec.imm            = imm_offs26;
            dec.reg_write_en   = (op6 == OP6_BL);
            dec.reg_write_addr = (op6 == OP6_BL) ? 5'd1 : 5'd0;   // link to r1
        end else if (op8 == OP8_CSR && (rj == 5'd0 || rj == 5'd1)) begin
            dec.aluop          = (rj == 5'd1) ? ALU_CSRWR : ALU_CSRRD;
            dec.alusel         = SEL_CSR;
            dec.is_privilege   = 1'b1;
            dec.csr_read_en    = 1'b1;
            dec.csr_write_en   = (rj == 5'd1);
            dec.csr_addr       = inst[23:10];
            dec.reg1_read_en   = (rj == 5'd1);   // csrwr source is rd
            dec.reg1_read_addr = (rj == 5'd1) ? rd : 5'd0;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
        end else if (inst[31:10] == OP22_RDCNT && rj == 5'd0) begin
            dec.aluop          = ALU_RDCNT;
            dec.alusel         = SEL_CSR;
            dec.is_cnt         = 1'b1;
            dec.reg_write_en   = 1'b1;
            dec.reg_write_addr = rd;
        end else if (op17 == OP17_INVTLB) begin
            dec.aluop          = ALU_INVTLB;
            dec.alusel         = SEL_PRIV;
            dec.is_privilege   = 1'b1;
            dec.invtlb_op      = rd;
            dec.reg1_read_en   = 1'b1;
            dec.reg1_read_addr = rj;
            dec.reg2_read_en   = 1'b1;
            dec.reg2_read_addr = rk;
        end else if (op17 == OP17_SYSCALL || op17 == OP17_BREAK) begin
            dec.aluop  = (op17 == OP17_SYSCALL) ? ALU_SYSCALL : ALU_BREAK;
            dec.alusel = SEL_PRIV;
            dec.imm    = imm_code;
            is_sys     = (op17 == OP17_SYSCALL);
            is_brk     = (op17 == OP17_BREAK);
        end else if (inst == INST_ERTN) begin
            dec.aluop        = ALU_ERTN;
            dec.alusel       = SEL_PRIV;
            dec.is_privilege = 1'b1;
        end else begin
            is_ine = 1'b1;
        end

        // fetch-side causes win over anything found here
        dec.is_exception               = {1'b0, slot.is_exception};
        dec.pc_exception_cause         = slot.pc_exception_cause;
        dec.instbuffer_exception_cause = slot.instbuffer_exception_cause;
        if (!fetch_exc && (is_ine || is_sys || is_brk)) begin
            dec.is_exception[2]         = 1'b1;
            dec.decoder_exception_cause = is_ine ? ECODE_INE : (is_sys ? ECODE_SYS : ECODE_BRK);
        end
    end

endmodule

// ==== testbench/tb_decoder.sv ====
module tb_decoder
    import decode_pkg::*;
;
    localparam int QUEUE_DEPTH = 8;

    logic          clk;
    logic          rst_n;
    logic          flush;
    logic [1:0]    fetch_valid;
    fetch_slot_t   fetch_slot [2];
    logic          stall;
    logic [1:0]    out_valid;
    decoded_inst_t out_inst [2];
    logic [1:0]    issue_ack;

    fetch_slot_t   stage_slot [2];    // next slots to drive
    decoded_inst_t exp_dec [2];       // their expected records
    decoded_inst_t model_q [$];
    integer        seed;
    int            err_cnt;
    int            check_cnt;

    decoder #(.QUEUE_DEPTH(QUEUE_DEPTH)) decoder_inst (
        .clk (clk), .rst_n (rst_n), .flush (flush),
        .fetch_valid (fetch_valid), .fetch_slot (fetch_slot), .stall (stall),
        .out_valid (out_valid), .out_inst (out_inst), .issue_ack (issue_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic decoded_inst_t with_regs(input decoded_inst_t d,
            input logic r1_en, input logic [4:0] r1, input logic r2_en, input logic [4:0] r2,
            input logic w_en, input logic [4:0] w);
        d.reg1_read_en   = r1_en;
        d.reg1_read_addr = r1;
        d.reg2_read_en   = r2_en;
        d.reg2_read_addr = r2;
        d.reg_write_en   = w_en;
        d.reg_write_addr = w;
        return d;
    endfunction

    // encode one instruction of the given kind and predict its record
    task automatic make_slot(input int idx, input int kind, input logic [1:0] exc);
        logic [16:0]   op3r [5] = '{17'h20, 17'h22, 17'h29, 17'h2A, 17'h2B};
        alu_op_e       alu3r [5] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
        logic [4:0]    rd;
        logic [4:0]    rj;
        logic [4:0]    rk;
        logic [25:0]   f;
        logic [6:0]    cause;
        fetch_slot_t   s;
        decoded_inst_t e;
        rd = 5'($random(seed));
        rj = 5'($random(seed));
        rk = 5'($random(seed));
        f  = 26'($random(seed));
        s = {32'($random(seed)) & 32'hFFFF_FFFC, 32'h0, 1'($random(seed)), 32'($random(seed)),
             exc, 7'($random(seed)), 7'($random(seed))};
        e = '0;
        cause = 7'h0;
        case (kind)
            0, 1, 2, 3, 4: begin
                s.inst   = {op3r[kind], rk, rj, rd};
                e.aluop  = alu3r[kind];
                e.alusel = (kind < 2) ? SEL_ARITH : SEL_LOGIC;
                e = with_regs(e, 1, rj, 1, rk, 1, rd);
            end
            5: begin
                s.inst = {17'h81, rk, rj, rd};
                {e.aluop, e.alusel, e.imm} = {ALU_SLL, SEL_SHIFT, 27'b0, rk};
                e = with_regs(e, 1, rj, 0, 0, 1, rd);
            end
            6, 8, 9: begin    // addi.w, ld.w, st.w share the si12 form
                s.inst = {(kind == 6) ? 10'h00A : (kind == 8) ? 10'h0A2 : 10'h0A6, f[11:0], rj, rd};
                e.aluop  = (kind == 6) ? ALU_ADD : (kind == 8) ? ALU_LOAD : ALU_STORE;
                e.alusel = (kind == 6) ? SEL_ARITH : SEL_MEM;
                e.imm    = {{20{f[11]}}, f[11:0]};
                e = with_regs(e, 1, rj, kind == 9, (kind == 9) ? rd : 5'd0, kind != 9,
                              (kind == 9) ? 5'd0 : rd);
            end
            7: begin
                s.inst = {7'h0A, f[19:0], rd};
                {e.aluop, e.alusel, e.imm} = {ALU_LUI, SEL_ARITH, f[19:0], 12'b0};
                e = with_regs(e, 0, 0, 0, 0, 1, rd);
            end
            10, 11: begin
                s.inst = {(kind == 10) ? 6'h16 : 6'h17, f[15:0], rj, rd};
                e.aluop  = (kind == 10) ? ALU_BEQ : ALU_BNE;
                e.alusel = SEL_BRANCH;
                e.imm    = {{14{f[15]}}, f[15:0], 2'b00};
                e = with_regs(e, 1, rj, 1, rd, 0, 0);
            end
            12, 13: begin
                s.inst = {(kind == 12) ? 6'h14 : 6'h15, f[15:0], f[25:16]};
                e.aluop  = (kind == 12) ? ALU_B : ALU_BL;
                e.alusel = SEL_BRANCH;
                e.imm    = {{4{f[25]}}, f, 2'b00};
                e = with_regs(e, 0, 0, 0, 0, kind == 13, (kind == 13) ? 5'd1 : 5'd0);
            end
            14, 15: begin    // rj 0 reads, rj 1 writes
                s.inst = {8'h04, f[13:0], 4'b0, kind == 15, rd};
                e.aluop  = (kind == 14) ? ALU_CSRRD : ALU_CSRWR;
                e.alusel = SEL_CSR;
                {e.is_privilege, e.csr_read_en, e.csr_write_en} = {2'b11, kind == 15};
                e.csr_addr = f[13:0];
                e = with_regs(e, kind == 15, (kind == 15) ? rd : 5'd0, 0, 0, 1, rd);
            end
            16: begin
                s.inst = {22'h18, 5'd0, rd};
                {e.aluop, e.alusel, e.is_cnt} = {ALU_RDCNT, SEL_CSR, 1'b1};
                e = with_regs(e, 0, 0, 0, 0, 1, rd);
            end
            17: begin
                s.inst = {17'hC93, rk, rj, rd};
                {e.aluop, e.alusel, e.is_privilege, e.invtlb_op} = {ALU_INVTLB, SEL_PRIV, 1'b1, rd};
                e = with_regs(e, 1, rj, 1, rk, 0, 0);
            end
            18, 19: begin
                s.inst = {(kind == 18) ? 17'h56 : 17'h54, f[14:0]};
                e.aluop  = (kind == 18) ? ALU_SYSCALL : ALU_BREAK;
                e.alusel = SEL_PRIV;
                e.imm    = {17'b0, f[14:0]};
                cause    = (kind == 18) ? ECODE_SYS : ECODE_BRK;
            end
            20: begin
                s.inst = 32'h0648_3800;
                {e.aluop, e.alusel, e.is_privilege} = {ALU_ERTN, SEL_PRIV, 1'b1};
            end
            default: begin
                s.inst = {6'h3F, f};    // no supported major opcode starts this way
                cause = ECODE_INE;
            end
        endcase
        {e.pc, e.inst, e.pre_taken, e.pre_addr} = {s.pc, s.inst, s.pre_taken, s.pre_addr};
        e.pc_exception_cause         = s.pc_exception_cause;
        e.instbuffer_exception_cause = s.instbuffer_exception_cause;
        e.is_exception = {(exc == 2'b00) && (cause != 7'h0), exc};
        e.decoder_exception_cause = (exc == 2'b00) ? cause : 7'h0;
        stage_slot[idx] = s;
        exp_dec[idx]    = e;
    endtask

    function automatic logic [1:0] legal_ack(input logic [1:0] want);
        logic a0;
        a0 = want[0] && (model_q.size() > 0);
        return {a0 && want[1] && (model_q.size() > 1), a0};
    endfunction

    task automatic make_random_pair();
        for (int i = 0; i < 2; i++) begin
            make_slot(i, $unsigned($random(seed)) % 22,
                      (($random(seed) & 7) == 0) ? 2'($random(seed)) : 2'b00);
        end
    endtask

    // called 2 units after an edge; checks outputs, drives, then advances one clock
    task automatic run_cycle(input logic [1:0] valid, input logic [1:0] ack, input logic fl);
        logic exp_stall;
        exp_stall = (QUEUE_DEPTH - model_q.size()) < 2;
        check("stall", stall, exp_stall);
        check("out_valid", out_valid, {model_q.size() > 1, model_q.size() > 0});
        if (model_q.size() > 0)
            check("out_inst[0]", out_inst[0], model_q[0]);
        if (model_q.size() > 1)
            check("out_inst[1]", out_inst[1], model_q[1]);
        fetch_valid = valid;
        fetch_slot  = stage_slot;
        issue_ack   = ack;
        flush       = fl;
        @(posedge clk);
        #2;
        if (fl) begin
            model_q.delete();
        end else begin
            for (int i = 0; i < 2; i++)
                if (ack[i])
                    void'(model_q.pop_front());
            for (int i = 0; i < 2; i++)
                if (valid[i] && !exp_stall)
                    model_q.push_back(exp_dec[i]);    // lone slot 1 still lands behind older ones
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (out_valid != 2'b00 && n < 2 * QUEUE_DEPTH) begin
            run_cycle(2'b00, legal_ack(2'b11), 1'b0);
            n++;
        end
        if (out_valid != 2'b00) begin
            err_cnt++;
            $display("queue still holds entries after %0d drain cycles", n);
        end
    endtask

    task automatic decode_each_kind();
        for (int k = 0; k < 22; k++) begin
            make_slot(k % 2, k, 2'b00);
            run_cycle((k % 2) ? 2'b10 : 2'b01, legal_ack(2'b01), 1'b0);
        end
        drain();
    endtask

    task automatic exception_causes();
        int kinds [4] = '{18, 19, 21, 6};
        for (int e = 0; e < 4; e++) begin
            for (int k = 0; k < 4; k++) begin
                make_slot(0, kinds[k], 2'(e));
                make_slot(1, kinds[3 - k], 2'(3 - e));
                run_cycle(2'b11, legal_ack(2'b11), 1'b0);
            end
        end
        drain();
    endtask

    task automatic slot_order();
        int n;
        n = 0;
        for (int i = 0; i < 9; i++) begin
            make_random_pair();
            run_cycle((i % 3 == 0) ? 2'b11 : (i % 3 == 1) ? 2'b10 : 2'b01,
                      legal_ack(2'b01), 1'b0);
        end
        while (model_q.size() > 0 && n < 2 * QUEUE_DEPTH) begin
            run_cycle(2'b00, legal_ack(2'b01), 1'b0);
            n++;
        end
        if (out_valid != 2'b00) begin
            err_cnt++;
            $display("queue still holds entries after %0d single-ack cycles", n);
        end
    endtask

    task automatic backpressure();
        int n;
        n = 0;
        make_random_pair();
        run_cycle(2'b01, 2'b00, 1'b0);
        while (!stall && n < 2 * QUEUE_DEPTH) begin
            make_random_pair();
            run_cycle(2'b11, 2'b00, 1'b0);
            n++;
        end
        if (!stall) begin
            err_cnt++;
            $display("stall did not rise while the queue filled");
        end
        for (int i = 0; i < 3; i++) begin
            make_random_pair();
            run_cycle(2'b11, 2'b00, 1'b0);    // held off, must not enter
        end
        drain();
        check("stall", stall, 1'b0);
    endtask

    task automatic flush_nonempty();
        for (int i = 0; i < 3; i++) begin
            make_random_pair();
            run_cycle(2'b11, 2'b00, 1'b0);
        end
        make_random_pair();
        run_cycle(2'b11, legal_ack(2'b11), 1'b1);
        for (int i = 0; i < 4; i++) begin
            make_random_pair();
            run_cycle(2'b11, legal_ack(2'b01), 1'b0);
        end
        drain();
    endtask

    task automatic random_stream();
        for (int i = 0; i < 300; i++) begin
            make_random_pair();
            run_cycle(2'($random(seed)), legal_ack(2'($random(seed))),
                      ($unsigned($random(seed)) % 40) == 0);
        end
        drain();
    endtask

    initial begin
        seed      = 94314;
        err_cnt   = 0;
        check_cnt = 0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        fetch_valid = 2'b00;
        issue_ack   = 2'b00;
        fetch_slot[0] = '0;
        fetch_slot[1] = '0;
        stage_slot    = fetch_slot;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        decode_each_kind();
        exception_causes();
        slot_order();
        backpressure();
        flush_nonempty();
        random_stream();
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
rtl/decode_pkg.sv
rtl/inst_decoder.sv
rtl/decode_queue.sv
rtl/decoder.sv
testbench/tb_decoder.sv
